// ==== hw/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    //////////////////////////////////////////////////////////////////////
    // geometry
    //////////////////////////////////////////////////////////////////////

    localparam int ADDR_W      = 32;
    localparam int WORD_W      = 32;
    localparam int OFFSET_BITS = 2;                                // byte in word
    localparam int SET_BITS    = 9;
    localparam int SETS        = 1 << SET_BITS;                    // 512
    localparam int WAYS        = 4;
    localparam int WAY_BITS    = 2;
    localparam int TAG_W       = ADDR_W - SET_BITS - OFFSET_BITS;  // 21
    localparam int AGE_W       = 4;
    localparam int AGE_MAX     = (1 << AGE_W) - 1;                 // saturates here

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [SET_BITS-1:0] index_t;
    typedef logic [WAY_BITS-1:0] way_t;
    typedef logic [AGE_W-1:0]    age_t;
    typedef logic [WORD_W/8-1:0] byte_en_t;  // lane k is bits 8k+7..8k

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE_BACK,
        ST_REFILL
    } cache_state_e;

    // same encoding as the processor port
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

endpackage

`default_nettype wire

// ==== hw/dcache_tag_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_tag_store (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire dcache_pkg::addr_t cpu_addr,
    input  wire dcache_pkg::way_t act_way,
    input  wire logic             fill_en,
    input  wire logic             store_en,
    input  wire dcache_pkg::way_t victim_way,
    output logic                  hit,
    output dcache_pkg::way_t      hit_way,
    output dcache_pkg::tag_t      victim_tag,
    output logic                  victim_dirty
);

    import dcache_pkg::*;

    logic valid_arr [WAYS][SETS];
    logic dirty_arr [WAYS][SETS];
    tag_t tag_arr   [WAYS][SETS];

    tag_t            addr_tag;
    index_t          index;
    logic [WAYS-1:0] match;

    assign addr_tag = cpu_addr[ADDR_W-1 -: TAG_W];
    assign index    = cpu_addr[OFFSET_BITS +: SET_BITS];

    //////////////////////////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            match[w] = valid_arr[w][index] && (tag_arr[w][index] == addr_tag);
        end
    end

    assign hit = |match;

    // encoder, lowest way wins if ever more than one
    always_comb begin
        hit_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // victim line as seen by the write-back path
    assign victim_tag   = tag_arr[victim_way][index];
    assign victim_dirty = valid_arr[victim_way][index] && dirty_arr[victim_way][index];

    //////////////////////////////////////////////////////////////////////
    // update
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    valid_arr[w][s] <= 1'b0;
                    dirty_arr[w][s] <= 1'b0;
                end
            end
        end else begin
            if (fill_en) begin
                valid_arr[act_way][index] <= 1'b1;
                dirty_arr[act_way][index] <= 1'b0;   // fresh from memory
            end else if (store_en) begin
                dirty_arr[act_way][index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_arr[act_way][index] <= addr_tag;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // a tag must never live in two ways of one set
    assert property (@(posedge clk) disable iff (rst) $onehot0(match))
        else $error("tag store: more than one way matches");

    // controller only refills on a miss, otherwise the line would be duplicated
    assert property (@(posedge clk) disable iff (rst) fill_en |-> !hit)
        else $error("tag store: refill while the address hits");

endmodule

`default_nettype wire

// ==== hw/dcache_data_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_data_store (
    input  wire logic                     clk,
    input  wire dcache_pkg::addr_t        cpu_addr,
    input  wire dcache_pkg::access_size_e cpu_size,
    input  wire dcache_pkg::word_t        cpu_wdata,
    input  wire dcache_pkg::word_t        mem_rdata,
    input  wire dcache_pkg::way_t         act_way,
    input  wire dcache_pkg::way_t         hit_way,
    input  wire dcache_pkg::way_t         victim_way,
    input  wire logic                     fill_en,
    input  wire logic                     store_en,
    output dcache_pkg::word_t             hit_word,
    output dcache_pkg::word_t             victim_word
);

    import dcache_pkg::*;

    // four byte lanes per line, one line per way and set
    logic [$bits(byte_en_t)-1:0][7:0] data_arr [WAYS][SETS];

    index_t                 index;
    logic [OFFSET_BITS-1:0] offset;
    byte_en_t               byte_en;

    assign index  = cpu_addr[OFFSET_BITS +: SET_BITS];
    assign offset = cpu_addr[OFFSET_BITS-1:0];

    //////////////////////////////////////////////////////////////////////
    // byte lanes from size and offset
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (cpu_size)
            SIZE_BYTE: byte_en = 4'b0001 << offset;
            SIZE_HALF: byte_en = 4'b0011 << offset;   // offset 0 or 2
            default:   byte_en = '1;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // writes
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_arr[act_way][index] <= mem_rdata;   // whole word
        end else if (store_en) begin
            for (int k = 0; k < $bits(byte_en_t); k++) begin
                if (byte_en[k]) begin
                    data_arr[act_way][index][k] <= cpu_wdata[8*k +: 8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reads
    //////////////////////////////////////////////////////////////////////

    assign hit_word    = data_arr[hit_way][index];
    assign victim_word = data_arr[victim_way][index];   // write-back data

    // misaligned stores would spill out of the word
    assert property (@(posedge clk)
        store_en |-> !((cpu_size == SIZE_HALF && offset[0]) ||
                       (cpu_size == SIZE_WORD && offset != '0)))
        else $error("data store: misaligned store, size %0d offset %0d",
                    cpu_size, offset);

endmodule

`default_nettype wire

// ==== hw/dcache_age_lru.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_age_lru (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire dcache_pkg::addr_t cpu_addr,
    input  wire dcache_pkg::way_t  act_way,
    input  wire logic              fill_en,
    input  wire logic              store_en,
    input  wire logic              read_hit_en,
    output dcache_pkg::way_t       victim_way
);

    import dcache_pkg::*;

    age_t   ages [WAYS][SETS];
    index_t index;
    logic   access_en;
    age_t   best_age;

    assign index     = cpu_addr[OFFSET_BITS +: SET_BITS];
    assign access_en = fill_en | store_en | read_hit_en;

    //////////////////////////////////////////////////////////////////////
    // age update
    //////////////////////////////////////////////////////////////////////

    // all ways start oldest, so empty ways are taken from way 0 up
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    ages[w][s] <= age_t'(AGE_MAX);
                end
            end
        end else if (access_en) begin
            for (int w = 0; w < WAYS; w++) begin
                if (way_t'(w) == act_way) begin
                    ages[w][index] <= '0;   // just used
                end else if (ages[w][index] != age_t'(AGE_MAX)) begin
                    ages[w][index] <= ages[w][index] + 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // victim choice
    //////////////////////////////////////////////////////////////////////

    // strict compare keeps ties on the lower way
    always_comb begin
        victim_way = '0;
        best_age   = ages[0][index];
        for (int w = 1; w < WAYS; w++) begin
            if (ages[w][index] > best_age) begin
                victim_way = way_t'(w);
                best_age   = ages[w][index];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/dcache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             cpu_req,
    input  wire logic             cpu_wr,
    input  wire logic             hit,
    input  wire dcache_pkg::way_t hit_way,
    input  wire dcache_pkg::way_t victim_way,
    input  wire logic             victim_dirty,
    input  wire logic             mem_ready,
    output logic                  cpu_ready,
    output logic                  mem_req,
    output logic                  mem_wr,
    output logic                  store_en,
    output logic                  fill_en,
    output logic                  read_hit_en,
    output dcache_pkg::way_t      act_way,
    output logic                  wb_sel
);

    import dcache_pkg::*;

    cache_state_e state;
    cache_state_e state_next;
    logic         idle;
    logic         hit_access;

    assign idle       = (state == ST_IDLE);
    assign hit_access = idle && cpu_req && hit;

    //////////////////////////////////////////////////////////////////////
    // miss FSM
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (cpu_req && !hit) begin
                    state_next = victim_dirty ? ST_WRITE_BACK : ST_REFILL;
                end
            end
            ST_WRITE_BACK: begin
                if (mem_ready) begin
                    state_next = ST_REFILL;   // victim now safe in memory
                end
            end
            ST_REFILL: begin
                if (mem_ready) begin
                    state_next = ST_IDLE;     // retry hits next cycle
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // strobes
    //////////////////////////////////////////////////////////////////////

    assign cpu_ready   = hit_access;
    assign store_en    = hit_access && cpu_wr;
    assign read_hit_en = hit_access && !cpu_wr;
    assign fill_en     = (state == ST_REFILL) && mem_ready;

    assign mem_req = !idle;
    assign mem_wr  = (state == ST_WRITE_BACK);
    assign wb_sel  = (state == ST_WRITE_BACK);   // victim address on the bus

    assign act_way = idle ? hit_way : victim_way;

    // only a dirty victim may be written out
    assert property (@(posedge clk) disable iff (rst) mem_wr |-> victim_dirty)
        else $error("ctrl: write-back of a line that is not dirty");

    // the refilled line must satisfy the held request
    assert property (@(posedge clk) disable iff (rst) fill_en |=> hit)
        else $error("ctrl: access does not hit after refill");

endmodule

`default_nettype wire

// ==== hw/dcache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module dcache_top (
    input  wire logic                     clk,
    input  wire logic                     rst,
    // processor side
    input  wire logic                     cpu_req,
    input  wire logic                     cpu_wr,
    input  wire dcache_pkg::access_size_e cpu_size,
    input  wire dcache_pkg::addr_t        cpu_addr,
    input  wire dcache_pkg::word_t        cpu_wdata,
    output wire dcache_pkg::word_t        cpu_rdata,
    output wire logic                     cpu_ready,
    // memory side
    output wire logic                     mem_req,
    output wire logic                     mem_wr,
    output wire dcache_pkg::addr_t        mem_addr,
    output wire dcache_pkg::word_t        mem_wdata,
    input  wire dcache_pkg::word_t        mem_rdata,
    input  wire logic                     mem_ready
);

    import dcache_pkg::*;

    logic hit;
    way_t hit_way;
    way_t victim_way;
    tag_t victim_tag;
    logic victim_dirty;
    way_t act_way;
    logic store_en;
    logic fill_en;
    logic read_hit_en;
    logic wb_sel;

    // write-back goes to the victim's line, refill to the requested one
    assign mem_addr = {wb_sel ? victim_tag : cpu_addr[ADDR_W-1 -: TAG_W],
                       cpu_addr[OFFSET_BITS +: SET_BITS],
                       {OFFSET_BITS{1'b0}}};

    dcache_tag_store u_tag_store (
        .clk          (clk),
        .rst          (rst),
        .cpu_addr     (cpu_addr),
        .act_way      (act_way),
        .fill_en      (fill_en),
        .store_en     (store_en),
        .victim_way   (victim_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    dcache_data_store u_data_store (
        .clk         (clk),
        .cpu_addr    (cpu_addr),
        .cpu_size    (cpu_size),
        .cpu_wdata   (cpu_wdata),
        .mem_rdata   (mem_rdata),
        .act_way     (act_way),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .fill_en     (fill_en),
        .store_en    (store_en),
        .hit_word    (cpu_rdata),
        .victim_word (mem_wdata)
    );

    dcache_age_lru u_age_lru (
        .clk         (clk),
        .rst         (rst),
        .cpu_addr    (cpu_addr),
        .act_way     (act_way),
        .fill_en     (fill_en),
        .store_en    (store_en),
        .read_hit_en (read_hit_en),
        .victim_way  (victim_way)
    );

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cpu_wr       (cpu_wr),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .mem_ready    (mem_ready),
        .cpu_ready    (cpu_ready),
        .mem_req      (mem_req),
        .mem_wr       (mem_wr),
        .store_en     (store_en),
        .fill_en      (fill_en),
        .read_hit_en  (read_hit_en),
        .act_way      (act_way),
        .wb_sel       (wb_sel)
    );

endmodule

`default_nettype wire

// ==== test/tb_dcache_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_dcache_mem (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              mem_req,
    input  wire logic              mem_wr,
    input  wire dcache_pkg::addr_t mem_addr,
    input  wire dcache_pkg::word_t mem_wdata,
    output dcache_pkg::word_t      mem_rdata,
    output logic                   mem_ready,
    output int                     wr_count,
    output int                     errors
);

    import dcache_pkg::*;

    word_t words [addr_t];   // only words written back live here
    logic  busy;
    int    wait_left;
    int    fail_count = 0;

    assign errors = fail_count;

    // fill pattern, mixes every address bit
    function automatic word_t addr_hash(input addr_t a);
        word_t h;
        h = a ^ 32'h5bd1_e995;
        h = h * 32'h2c1b_3c6d;
        h = h ^ (h >> 15);
        return h;
    endfunction

    function automatic word_t fetch_word(input addr_t a);
        if (words.exists(a)) begin
            return words[a];
        end
        return addr_hash(a);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // transfer with random latency
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            mem_ready <= 1'b0;
            mem_rdata <= '0;
            busy      <= 1'b0;
            wait_left <= 0;
            wr_count  <= 0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;   // one-cycle strobe
        end else if (mem_req) begin
            if (!busy) begin
                busy      <= 1'b1;
                wait_left <= int'($urandom_range(5, 0));
            end else if (wait_left != 0) begin
                wait_left <= wait_left - 1;
            end else begin
                busy      <= 1'b0;
                mem_ready <= 1'b1;
                if (mem_wr) begin
                    words[mem_addr] = mem_wdata;
                    wr_count <= wr_count + 1;   // write log
                end else begin
                    mem_rdata <= fetch_word(mem_addr);
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus rules
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ready |=> mem_req && $stable(mem_wr) && $stable(mem_addr) &&
                                  (!mem_wr || $stable(mem_wdata)))
        else begin
            fail_count = fail_count + 1;
            $display("Fail %0t: memory request changed before mem_ready", $time);
        end

    assert property (@(posedge clk) disable iff (rst) mem_req |-> mem_addr[1:0] == 2'b00)
        else begin
            fail_count = fail_count + 1;
            $display("Fail %0t: memory address %h not word aligned", $time,
                     $sampled(mem_addr));
        end

endmodule

`default_nettype wire

// ==== test/tb_dcache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;

    import dcache_pkg::*;

    localparam int CLK_HALF          = 10;
    localparam int RESET_CYCLES      = 10;
    localparam int RANDOM_ACCESSES   = 200;
    localparam int DIRECTED_ACCESSES = 30;
    localparam int WATCHDOG_CYCLES   =
        (RANDOM_ACCESSES + DIRECTED_ACCESSES) * 40 + RESET_CYCLES;
    localparam tag_t TAG_BASE = 21'h0abc0;   // low 3 bits carry the tag number
    localparam int WB_ANY  = 0;
    localparam int WB_NONE = 1;
    localparam int WB_ONE  = 2;

    logic         clk;
    logic         rst;
    logic         cpu_req;
    logic         cpu_wr;
    access_size_e cpu_size;
    addr_t        cpu_addr;
    word_t        cpu_wdata;
    word_t        cpu_rdata;
    logic         cpu_ready;
    logic         mem_req;
    logic         mem_wr;
    addr_t        mem_addr;
    word_t        mem_wdata;
    word_t        mem_rdata;
    logic         mem_ready;
    int           wr_count;
    int           mem_errors;
    int           cpu_errors;

    // expected word per {tag number, set number}
    word_t      ref_mem [32];
    word_t      ref_at_cpu;
    word_t      ref_at_mem;
    logic       hit_expected;
    int         wb_mode;
    addr_t      wb_addr;
    int         wb_base;

    function automatic addr_t make_addr(input int tag_num, input int set_num, input int offset);
        tag_t   tag;
        index_t index;
        tag   = TAG_BASE | tag_t'(tag_num & 7);
        index = {set_num[1:0], 7'h05};
        return {tag, index, offset[1:0]};
    endfunction

    function automatic logic [4:0] key_of(input addr_t a);
        return {a[13:11], a[10:9]};
    endfunction

    // little-endian lanes, store data already in place
    function automatic word_t merge_store(input word_t old, input word_t wdata,
                                          input access_size_e size, input int offset);
        word_t result;
        result = old;
        for (int k = 0; k < 4; k++) begin
            if (size == SIZE_WORD || k == offset || (size == SIZE_HALF && k == offset + 1)) begin
                result[8*k +: 8] = wdata[8*k +: 8];
            end
        end
        return result;
    endfunction

    assign ref_at_cpu = ref_mem[key_of(cpu_addr)];
    assign ref_at_mem = ref_mem[key_of(mem_addr)];

    dcache_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_wr    (cpu_wr),
        .cpu_size  (cpu_size),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_ready (cpu_ready),
        .mem_req   (mem_req),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    tb_dcache_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_wr    (mem_wr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .wr_count  (wr_count),
        .errors    (mem_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    assert property (@(posedge clk) rst || $past(rst) |-> !cpu_ready && !mem_req)
        else begin
            cpu_errors = cpu_errors + 1;
            $display("Fail %0t: cpu_ready or mem_req high around reset", $time);
        end

    assert property (@(posedge clk) disable iff (rst)
        cpu_req && cpu_ready && !cpu_wr |-> cpu_rdata == ref_at_cpu)
        else begin
            cpu_errors = cpu_errors + 1;
            $display("Fail %0t: read of %h returned %h, expected %h", $time,
                     $sampled(cpu_addr), $sampled(cpu_rdata), $sampled(ref_at_cpu));
        end

    assert property (@(posedge clk) disable iff (rst)
        hit_expected && cpu_req |-> cpu_ready && !mem_req)
        else begin
            cpu_errors = cpu_errors + 1;
            $display("Fail %0t: access to %h did not hit", $time, $sampled(cpu_addr));
        end

    assert property (@(posedge clk) disable iff (rst) wb_mode == WB_NONE |-> !mem_wr)
        else begin
            cpu_errors = cpu_errors + 1;
            $display("Fail %0t: memory write to %h before any eviction", $time,
                     $sampled(mem_addr));
        end

    assert property (@(posedge clk) disable iff (rst)
        wb_mode == WB_ONE && mem_wr && mem_ready |-> mem_addr == wb_addr)
        else begin
            cpu_errors = cpu_errors + 1;
            $display("Fail %0t: write-back to %h, expected %h", $time,
                     $sampled(mem_addr), $sampled(wb_addr));
        end

    assert property (@(posedge clk) disable iff (rst)
        wb_mode == WB_ONE && cpu_ready |-> wr_count == wb_base + 1)
        else begin
            cpu_errors = cpu_errors + 1;
            $display("Fail %0t: %0d memory writes, expected one", $time,
                     $sampled(wr_count) - $sampled(wb_base));
        end

    assert property (@(posedge clk) disable iff (rst)
        mem_wr && mem_ready |-> mem_wdata == ref_at_mem)
        else begin
            cpu_errors = cpu_errors + 1;
            $display("Fail %0t: write-back data %h, expected %h", $time,
                     $sampled(mem_wdata), $sampled(ref_at_mem));
        end

    assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_wr |-> mem_addr == {cpu_addr[31:2], 2'b00})
        else begin
            cpu_errors = cpu_errors + 1;
            $display("Fail %0t: refill address %h for access %h", $time,
                     $sampled(mem_addr), $sampled(cpu_addr));
        end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic access(input logic wr, input access_size_e size, input addr_t addr,
                          input word_t wdata, input logic want_hit);
        @(posedge clk);
        cpu_req      <= 1'b1;
        cpu_wr       <= wr;
        cpu_size     <= size;
        cpu_addr     <= addr;
        cpu_wdata    <= wdata;
        hit_expected <= want_hit;
        @(negedge clk);
        while (!cpu_ready) @(negedge clk);
        @(posedge clk);   // access completes here
        cpu_req      <= 1'b0;
        hit_expected <= 1'b0;
        if (wr) begin
            ref_mem[key_of(addr)] <= merge_store(ref_mem[key_of(addr)], wdata, size,
                                                 int'(addr[1:0]));
        end
    endtask

    task automatic expect_writes(input int mode, input addr_t addr);
        wb_mode <= mode;
        wb_addr <= addr;
        wb_base <= wr_count;
    endtask

    initial begin
        access_size_e size;
        int           off;
        void'($urandom(32'h8d01_142d));
        cpu_errors   = 0;
        rst          = 1'b1;
        cpu_req      = 1'b1;   // first read already waits through reset
        cpu_wr       = 1'b0;
        cpu_size     = SIZE_WORD;
        cpu_addr     = make_addr(0, 0, 0);
        cpu_wdata    = '0;
        hit_expected = 1'b0;
        wb_mode      = WB_NONE;
        wb_addr      = '0;
        wb_base      = 0;
        for (int k = 0; k < 32; k++) begin
            ref_mem[k] = u_mem.addr_hash(make_addr(k >> 2, k & 3, 0));
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // first reads refill, repeats hit
        access(1'b0, SIZE_WORD, make_addr(0, 0, 0), '0, 1'b0);
        access(1'b0, SIZE_WORD, make_addr(0, 0, 0), '0, 1'b1);
        access(1'b0, SIZE_WORD, make_addr(1, 1, 0), '0, 1'b0);
        access(1'b0, SIZE_WORD, make_addr(1, 1, 0), '0, 1'b1);

        // store hits of every size, each read back
        for (int i = 0; i < 5; i++) begin
            size = (i < 2) ? SIZE_BYTE : (i < 4) ? SIZE_HALF : SIZE_WORD;
            off  = (i == 0) ? 1 : (i == 1) ? 3 : (i == 2) ? 2 : 0;
            access(1'b1, size, make_addr(0, 0, off), $urandom(), 1'b1);
            access(1'b0, SIZE_WORD, make_addr(0, 0, 0), '0, 1'b1);
        end

        // five tags in set 2, the fifth evicts the first
        for (int t = 0; t < 4; t++) begin
            access(1'b1, SIZE_WORD, make_addr(t, 2, 0), $urandom(), 1'b0);
        end
        expect_writes(WB_ONE, make_addr(0, 2, 0));
        access(1'b1, SIZE_HALF, make_addr(4, 2, 2), $urandom(), 1'b0);
        expect_writes(WB_ANY, '0);
        access(1'b0, SIZE_WORD, make_addr(4, 2, 0), '0, 1'b1);
        access(1'b0, SIZE_WORD, make_addr(0, 2, 0), '0, 1'b0);   // comes back from memory

        // re-read of the first makes the second the oldest
        expect_writes(WB_NONE, '0);
        for (int t = 0; t < 4; t++) begin
            access(1'b1, SIZE_WORD, make_addr(t, 3, 0), $urandom(), 1'b0);
        end
        access(1'b0, SIZE_WORD, make_addr(0, 3, 0), '0, 1'b1);
        expect_writes(WB_ONE, make_addr(1, 3, 0));
        access(1'b0, SIZE_WORD, make_addr(4, 3, 0), '0, 1'b0);
        expect_writes(WB_NONE, '0);
        access(1'b0, SIZE_WORD, make_addr(0, 3, 0), '0, 1'b1);

        // mixed traffic over four sets and eight tags
        expect_writes(WB_ANY, '0);
        for (int n = 0; n < RANDOM_ACCESSES; n++) begin
            size = access_size_e'($urandom_range(2, 0));
            case (size)
                SIZE_BYTE: off = $urandom_range(3, 0);
                SIZE_HALF: off = 2 * $urandom_range(1, 0);
                default:   off = 0;
            endcase
            access($urandom_range(1, 0) == 1, size,
                   make_addr($urandom_range(7, 0), $urandom_range(3, 0), off),
                   $urandom(), 1'b0);
        end

        repeat (2) @(posedge clk);
        $display("error counts: testbench %0d, memory model %0d", cpu_errors, mem_errors);
        if (cpu_errors == 0 && mem_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: accesses still pending after %0d cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hw/dcache_pkg.sv
hw/dcache_tag_store.sv
hw/dcache_data_store.sv
hw/dcache_age_lru.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
test/tb_dcache_mem.sv
test/tb_dcache.sv

// ==== Makefile ====
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := tb_dcache
FLIST := all.f
OBJ   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

# pass only if the simulation printed the pass line
run: compile
	@out="$$(./$(OBJ)/V$(TOP))"; status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ)
